// File: hdl/mips_isa_pkg.sv
package mips_isa_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_w = 6;
    localparam int funct_w = 6;
    localparam int imm_w = 16;
    localparam int shamt_w = 5;
    localparam int jidx_w = 26;

    // boot rom entry in kseg1
    localparam logic [xlen-1:0] reset_pc = 32'hbfc0_0000;
    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

    // major opcode in bits 31:26
    typedef enum logic [opcode_w-1:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // funct field of SPECIAL
    typedef enum logic [funct_w-1:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

endpackage

// File: hdl/core_uarch_pkg.sv
package core_uarch_pkg;

    // one instruction in flight
    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        EXECUTE,
        MEM_WAIT,
        WRITEBACK
    } ctrl_state_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {B_RT, B_SIGN_IMM, B_ZERO_IMM} alu_b_sel_e;
    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;

    // word transfers only
    localparam logic [1:0] bus_size_word = 2'd2;
    localparam logic [3:0] bus_strb_all = 4'b1111;

endpackage

// File: hdl/reg_file.sv
module reg_file (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic [4:0]  waddr,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 hardwired to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'h0000_0000 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'h0000_0000 : regs[raddr2];

endmodule

// File: hdl/alu.sv
module alu (
    input  logic                       [31:0] rs_data,
    input  logic                       [31:0] rt_data,
    input  logic                       [15:0] imm16,
    input  logic                       [4:0]  shamt,
    input  core_uarch_pkg::alu_op_e           op,
    input  core_uarch_pkg::alu_b_sel_e        b_sel,
    output logic                       [31:0] result,
    output logic                              zero
);
    import core_uarch_pkg::*;

    logic [31:0] b;

    always_comb begin
        case (b_sel)
            B_SIGN_IMM: b = {{16{imm16[15]}}, imm16};
            B_ZERO_IMM: b = {16'h0000, imm16};
            default: b = rt_data;
        endcase
    end

    // shifts act on the second operand
    always_comb begin
        case (op)
            ALU_ADD: result = rs_data + b;
            ALU_SUB: result = rs_data - b;
            ALU_AND: result = rs_data & b;
            ALU_OR: result = rs_data | b;
            ALU_XOR: result = rs_data ^ b;
            ALU_NOR: result = ~(rs_data | b);
            ALU_SLT: result = {31'd0, $signed(rs_data) < $signed(b)};
            ALU_SLTU: result = {31'd0, rs_data < b};
            ALU_SLL: result = b << shamt;
            ALU_SRL: result = b >> shamt;
            ALU_SRA: result = $unsigned($signed(b) >>> shamt);
            ALU_LUI: result = {b[15:0], 16'h0000};
            default: result = 32'h0000_0000;
        endcase
    end

    // beq/bne look at this after a subtract
    assign zero = (result == 32'h0000_0000);

endmodule

// File: hdl/sram_master.sv
module sram_master (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start,
    input  logic        wr,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic        sram_req,
    output logic        sram_wr,
    output logic [3:0]  sram_wstrb,
    output logic [31:0] sram_addr,
    output logic [31:0] sram_wdata,
    input  logic        addr_ok,
    input  logic        data_ok,
    input  logic [31:0] sram_rdata,
    output logic        done,
    output logic [31:0] rdata
);
    import core_uarch_pkg::*;

    logic waiting;
    logic [31:0] phys_addr;

    // kseg0/kseg1 fold onto the low 512 MB, other segments pass through
    assign phys_addr = (addr[31:30] == 2'b10) ? {3'b000, addr[28:0]} : addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sram_req <= 1'b0;
            sram_wr <= 1'b0;
            waiting <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= waiting && data_ok;
            if (start) begin
                sram_req <= 1'b1;
                sram_wr <= wr;
            end else if (sram_req && addr_ok) begin
                sram_req <= 1'b0;
                waiting <= 1'b1;
            end
            if (waiting && data_ok) begin
                waiting <= 1'b0;
            end
        end
    end

    // address and data stay put while req is up
    always_ff @(posedge clk) begin
        if (start) begin
            sram_addr <= phys_addr;
            sram_wdata <= wdata;
        end
        if (waiting && data_ok) begin
            rdata <= sram_rdata;
        end
    end

    assign sram_wstrb = sram_wr ? bus_strb_all : 4'b0000;

endmodule

// File: hdl/pc_unit.sv
module pc_unit (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              load,
    input  core_uarch_pkg::pc_sel_e           sel,
    input  logic [mips_isa_pkg::imm_w-1:0]    imm16,
    input  logic [mips_isa_pkg::jidx_w-1:0]   jidx,
    input  logic [mips_isa_pkg::xlen-1:0]     rs_data,
    output logic [mips_isa_pkg::xlen-1:0]     pc,
    output logic [mips_isa_pkg::xlen-1:0]     pc_plus4
);
    import mips_isa_pkg::*;
    import core_uarch_pkg::*;

    logic [xlen-1:0] branch_target;
    logic [xlen-1:0] jump_target;
    logic [xlen-1:0] pc_next;

    assign pc_plus4 = pc + 32'd4;
    assign branch_target = pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};
    // stays inside the current 256 MB region
    assign jump_target = {pc_plus4[31:28], jidx, 2'b00};

    always_comb begin
        case (sel)
            PC_BRANCH: pc_next = branch_target;
            PC_JUMP: pc_next = jump_target;
            PC_REG: pc_next = rs_data;
            default: pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else if (load) begin
            pc <= pc_next;
        end
    end

endmodule

// File: hdl/core_ctrl.sv
module core_ctrl (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [mips_isa_pkg::xlen-1:0]       inst_rdata,
    input  logic                                inst_done,
    input  logic                                data_done,
    input  logic                                alu_zero,
    output logic                                inst_start,
    output logic                                data_start,
    output logic                                data_wr,
    output logic [mips_isa_pkg::reg_addr_w-1:0] rs,
    output logic [mips_isa_pkg::reg_addr_w-1:0] rt,
    output logic [mips_isa_pkg::reg_addr_w-1:0] waddr,
    output logic [mips_isa_pkg::imm_w-1:0]      imm16,
    output logic [mips_isa_pkg::shamt_w-1:0]    shamt,
    output logic [mips_isa_pkg::jidx_w-1:0]     jidx,
    output core_uarch_pkg::alu_op_e             alu_op,
    output core_uarch_pkg::alu_b_sel_e          alu_b_sel,
    output core_uarch_pkg::wb_sel_e             wb_sel,
    output core_uarch_pkg::pc_sel_e             pc_sel,
    output logic                                pc_load,
    output logic                                rf_we
);
    import mips_isa_pkg::*;
    import core_uarch_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic [xlen-1:0] ir;
    opcode_e opcode;
    funct_e funct;
    logic [reg_addr_w-1:0] rd;
    logic writes;
    logic dest_rd;
    logic dest_link;
    logic is_mem;
    logic is_store;

    assign opcode = opcode_e'(ir[31:26]);
    assign rs = ir[25:21];
    assign rt = ir[20:16];
    assign rd = ir[15:11];
    assign shamt = ir[10:6];
    assign funct = funct_e'(ir[5:0]);
    assign imm16 = ir[15:0];
    assign jidx = ir[25:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FETCH: state_next = FETCH_WAIT;
            FETCH_WAIT: if (inst_done) state_next = EXECUTE;
            EXECUTE: state_next = is_mem ? MEM_WAIT : WRITEBACK;
            MEM_WAIT: if (data_done) state_next = WRITEBACK;
            WRITEBACK: state_next = FETCH;
            default: state_next = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_WAIT && inst_done) begin
            ir <= inst_rdata;
        end
    end

    // decode; unknown encodings fall through as no-ops
    always_comb begin
        alu_op = ALU_ADD;
        alu_b_sel = B_RT;
        wb_sel = WB_ALU;
        pc_sel = PC_SEQ;
        writes = 1'b0;
        dest_rd = 1'b0;
        dest_link = 1'b0;
        is_mem = 1'b0;
        is_store = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                dest_rd = 1'b1;
                writes = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND: alu_op = ALU_AND;
                    FN_OR: alu_op = ALU_OR;
                    FN_XOR: alu_op = ALU_XOR;
                    FN_NOR: alu_op = ALU_NOR;
                    FN_SLT: alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL: alu_op = ALU_SLL;
                    FN_SRL: alu_op = ALU_SRL;
                    FN_SRA: alu_op = ALU_SRA;
                    FN_JR: begin
                        writes = 1'b0;
                        pc_sel = PC_REG;
                    end
                    default: writes = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_b_sel = B_SIGN_IMM;
                writes = 1'b1;
            end
            OP_SLTI: begin
                alu_op = ALU_SLT;
                alu_b_sel = B_SIGN_IMM;
                writes = 1'b1;
            end
            OP_SLTIU: begin
                // immediate is sign-extended, then compared unsigned
                alu_op = ALU_SLTU;
                alu_b_sel = B_SIGN_IMM;
                writes = 1'b1;
            end
            OP_ANDI: begin
                alu_op = ALU_AND;
                alu_b_sel = B_ZERO_IMM;
                writes = 1'b1;
            end
            OP_ORI: begin
                alu_op = ALU_OR;
                alu_b_sel = B_ZERO_IMM;
                writes = 1'b1;
            end
            OP_XORI: begin
                alu_op = ALU_XOR;
                alu_b_sel = B_ZERO_IMM;
                writes = 1'b1;
            end
            OP_LUI: begin
                alu_op = ALU_LUI;
                alu_b_sel = B_ZERO_IMM;
                writes = 1'b1;
            end
            OP_LW: begin
                alu_b_sel = B_SIGN_IMM;
                wb_sel = WB_MEM;
                writes = 1'b1;
                is_mem = 1'b1;
            end
            OP_SW: begin
                alu_b_sel = B_SIGN_IMM;
                is_mem = 1'b1;
                is_store = 1'b1;
            end
            OP_BEQ: begin
                alu_op = ALU_SUB;
                if (alu_zero) pc_sel = PC_BRANCH;
            end
            OP_BNE: begin
                alu_op = ALU_SUB;
                if (!alu_zero) pc_sel = PC_BRANCH;
            end
            OP_J: pc_sel = PC_JUMP;
            OP_JAL: begin
                pc_sel = PC_JUMP;
                wb_sel = WB_LINK;
                writes = 1'b1;
                dest_link = 1'b1;
            end
            default: ;
        endcase
    end

    assign waddr = dest_link ? link_reg : (dest_rd ? rd : rt);

    assign inst_start = (state == FETCH);
    assign data_start = (state == EXECUTE) && is_mem;
    assign data_wr = is_store;
    assign pc_load = (state == WRITEBACK);
    // r0 is never written
    assign rf_we = (state == WRITEBACK) && writes && (waddr != '0);

endmodule

// File: hdl/mycpu_top.sv
module mycpu_top (
    input  logic                            clk,
    input  logic                            arst_n,

    output logic                            inst_sram_req,
    output logic                            inst_sram_wr,
    output logic [1:0]                      inst_sram_size,
    output logic [3:0]                      inst_sram_wstrb,
    output logic [mips_isa_pkg::xlen-1:0]   inst_sram_addr,
    output logic [mips_isa_pkg::xlen-1:0]   inst_sram_wdata,
    input  logic                            inst_sram_addr_ok,
    input  logic                            inst_sram_data_ok,
    input  logic [mips_isa_pkg::xlen-1:0]   inst_sram_rdata,

    output logic                            data_sram_req,
    output logic                            data_sram_wr,
    output logic [1:0]                      data_sram_size,
    output logic [3:0]                      data_sram_wstrb,
    output logic [mips_isa_pkg::xlen-1:0]   data_sram_addr,
    output logic [mips_isa_pkg::xlen-1:0]   data_sram_wdata,
    input  logic                            data_sram_addr_ok,
    input  logic                            data_sram_data_ok,
    input  logic [mips_isa_pkg::xlen-1:0]   data_sram_rdata,

    output logic [mips_isa_pkg::xlen-1:0]   debug_wb_pc,
    output logic [3:0]                      debug_wb_rf_wen,
    output logic [4:0]                      debug_wb_rf_wnum,
    output logic [mips_isa_pkg::xlen-1:0]   debug_wb_rf_wdata
);
    import mips_isa_pkg::*;
    import core_uarch_pkg::*;

    logic inst_start;
    logic inst_done;
    logic data_start;
    logic data_done;
    logic data_wr;
    logic [xlen-1:0] inst_rdata;
    logic [xlen-1:0] data_rdata;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] waddr;
    logic [imm_w-1:0] imm16;
    logic [shamt_w-1:0] shamt;
    logic [jidx_w-1:0] jidx;
    alu_op_e alu_op;
    alu_b_sel_e alu_b_sel;
    wb_sel_e wb_sel;
    pc_sel_e pc_sel;
    logic pc_load;
    logic rf_we;
    logic [xlen-1:0] rs_data;
    logic [xlen-1:0] rt_data;
    logic [xlen-1:0] alu_result;
    logic alu_zero;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] wb_data;

    core_ctrl ctrl_i (
        .clk(clk), .arst_n(arst_n),
        .inst_rdata(inst_rdata), .inst_done(inst_done), .data_done(data_done),
        .alu_zero(alu_zero),
        .inst_start(inst_start), .data_start(data_start), .data_wr(data_wr),
        .rs(rs), .rt(rt), .waddr(waddr),
        .imm16(imm16), .shamt(shamt), .jidx(jidx),
        .alu_op(alu_op), .alu_b_sel(alu_b_sel), .wb_sel(wb_sel), .pc_sel(pc_sel),
        .pc_load(pc_load), .rf_we(rf_we)
    );

    reg_file rf_i (
        .clk(clk), .raddr1(rs), .raddr2(rt), .waddr(waddr),
        .we(rf_we), .wdata(wb_data), .rdata1(rs_data), .rdata2(rt_data)
    );

    alu alu_i (
        .rs_data(rs_data), .rt_data(rt_data), .imm16(imm16), .shamt(shamt),
        .op(alu_op), .b_sel(alu_b_sel), .result(alu_result), .zero(alu_zero)
    );

    pc_unit pc_i (
        .clk(clk), .arst_n(arst_n), .load(pc_load), .sel(pc_sel),
        .imm16(imm16), .jidx(jidx), .rs_data(rs_data),
        .pc(pc), .pc_plus4(pc_plus4)
    );

    // fetch port is read-only
    sram_master inst_master_i (
        .clk(clk), .arst_n(arst_n),
        .start(inst_start), .wr(1'b0), .addr(pc), .wdata('0),
        .sram_req(inst_sram_req), .sram_wr(inst_sram_wr), .sram_wstrb(inst_sram_wstrb),
        .sram_addr(inst_sram_addr), .sram_wdata(inst_sram_wdata),
        .addr_ok(inst_sram_addr_ok), .data_ok(inst_sram_data_ok),
        .sram_rdata(inst_sram_rdata), .done(inst_done), .rdata(inst_rdata)
    );

    sram_master data_master_i (
        .clk(clk), .arst_n(arst_n),
        .start(data_start), .wr(data_wr), .addr(alu_result), .wdata(rt_data),
        .sram_req(data_sram_req), .sram_wr(data_sram_wr), .sram_wstrb(data_sram_wstrb),
        .sram_addr(data_sram_addr), .sram_wdata(data_sram_wdata),
        .addr_ok(data_sram_addr_ok), .data_ok(data_sram_data_ok),
        .sram_rdata(data_sram_rdata), .done(data_done), .rdata(data_rdata)
    );

    assign inst_sram_size = bus_size_word;
    assign data_sram_size = bus_size_word;

    always_comb begin
        case (wb_sel)
            WB_MEM: wb_data = data_rdata;
            WB_LINK: wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

    // pc still holds the retiring instruction during writeback
    assign debug_wb_pc = pc;
    assign debug_wb_rf_wen = {4{rf_we}};
    assign debug_wb_rf_wnum = waddr;
    assign debug_wb_rf_wdata = wb_data;

endmodule

// File: verification/sram_model.sv
module sram_model (
    input  logic        clk,
    input  logic        inst_sram_req,
    input  logic [31:0] inst_sram_addr,
    output logic        inst_sram_addr_ok,
    output logic        inst_sram_data_ok,
    output logic [31:0] inst_sram_rdata,
    input  logic        data_sram_req,
    input  logic        data_sram_wr,
    input  logic [3:0]  data_sram_wstrb,
    input  logic [31:0] data_sram_addr,
    input  logic [31:0] data_sram_wdata,
    output logic        data_sram_addr_ok,
    output logic        data_sram_data_ok,
    output logic [31:0] data_sram_rdata
);
    timeunit 1ns;
    timeprecision 1ns;

    localparam int max_addr_wait = 3;
    // data_ok comes 1 to 3 cycles after acceptance
    localparam int max_data_wait = 2;

    logic [31:0] mem [1024];

    // port 0 is fetch, port 1 is data
    logic [1:0] req;
    logic [1:0] wr;
    logic [31:0] addr [2];
    logic [31:0] wdata [2];
    logic [1:0] addr_ok = 2'b00;
    logic [1:0] data_ok = 2'b00;
    logic [1:0] busy = 2'b00;
    logic [31:0] rdata [2] = '{32'h0, 32'h0};
    logic [9:0] idx [2];
    int unsigned addr_wait [2];
    int unsigned data_wait [2];

    assign req = {data_sram_req, inst_sram_req};
    assign wr = {data_sram_wr && (data_sram_wstrb == 4'hf), 1'b0};
    assign addr[0] = inst_sram_addr;
    assign addr[1] = data_sram_addr;
    assign wdata[0] = 32'h0;
    assign wdata[1] = data_sram_wdata;

    assign inst_sram_addr_ok = addr_ok[0];
    assign inst_sram_data_ok = data_ok[0];
    assign inst_sram_rdata = rdata[0];
    assign data_sram_addr_ok = addr_ok[1];
    assign data_sram_data_ok = data_ok[1];
    assign data_sram_rdata = rdata[1];

    always @(negedge clk) begin
        for (int p = 0; p < 2; p++) begin
            data_ok[p] = 1'b0;
            if (addr_ok[p]) begin
                // accepted on the rising edge just past
                addr_ok[p] = 1'b0;
                idx[p] = addr[p][11:2];
                if (wr[p]) begin
                    mem[idx[p]] = wdata[p];
                end
                busy[p] = 1'b1;
                data_wait[p] = $urandom_range(max_data_wait, 0);
                addr_wait[p] = $urandom_range(max_addr_wait, 0);
            end else if (req[p] && !busy[p]) begin
                if (addr_wait[p] == 0) begin
                    addr_ok[p] = 1'b1;
                end else begin
                    addr_wait[p]--;
                end
            end
            if (busy[p]) begin
                if (data_wait[p] == 0) begin
                    data_ok[p] = 1'b1;
                    rdata[p] = mem[idx[p]];
                    busy[p] = 1'b0;
                end else begin
                    data_wait[p]--;
                end
            end
        end
    end

endmodule

// File: verification/cpu_tb.sv
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import mips_isa_pkg::*;

    localparam logic [31:0] seed = 32'h464b_432e;
    localparam int alu_block_len = 60;
    localparam int mem_ops = 20;
    localparam int data_base = 512;
    localparam funct_e r_ops [11] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                                      FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
    localparam opcode_e i_ops [7] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                      OP_XORI, OP_LUI};

    logic clk;
    logic arst_n;
    logic inst_sram_req;
    logic inst_sram_wr;
    logic [1:0] inst_sram_size;
    logic [3:0] inst_sram_wstrb;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic inst_sram_addr_ok;
    logic inst_sram_data_ok;
    logic [31:0] inst_sram_rdata;
    logic data_sram_req;
    logic data_sram_wr;
    logic [1:0] data_sram_size;
    logic [3:0] data_sram_wstrb;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic data_sram_addr_ok;
    logic data_sram_data_ok;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    logic [4:0] debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // architectural reference state
    logic [31:0] ref_mem [1024];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    logic [31:0] prog [$];
    logic [31:0] halt_pc;
    logic [31:0] fetched_inst;
    int cycles;
    int checks;
    int mismatches;
    int other_errors;

    mycpu_top dut_i (.*);
    sram_model mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // instruction word last returned on the fetch port
    always @(posedge clk) begin
        if (inst_sram_data_ok) begin
            fetched_inst <= inst_sram_rdata;
        end
    end

    function automatic logic [31:0] r_type(funct_e fn, int rs, int rt, int rd, int sh);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] i_type(opcode_e op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // target given as a word index from reset_pc
    function automatic logic [31:0] j_type(opcode_e op, int idx);
        logic [31:0] t;
        t = reset_pc + 32'(idx) * 4;
        return {op, t[27:2]};
    endfunction

    function automatic void emit(logic [31:0] w);
        prog.push_back(w);
    endfunction

    task automatic build_program();
        funct_e fn;
        opcode_e op;
        int p;
        for (int r = 1; r < 32; r++) begin
            emit(i_type(OP_ADDIU, 0, r, 16'($urandom)));
        end
        // r0 is written but must stay zero
        emit(r_type(FN_ADDU, 1, 2, 0, 0));
        emit(i_type(OP_ADDIU, 0, 0, 16'h1234));
        emit(r_type(FN_OR, 0, 0, 17, 0));
        for (int n = 0; n < alu_block_len; n++) begin
            if ($urandom_range(1) == 1) begin
                fn = r_ops[$urandom_range(10)];
                emit(r_type(fn, $urandom_range(31), $urandom_range(31), $urandom_range(31),
                            (fn inside {FN_SLL, FN_SRL, FN_SRA}) ? $urandom_range(31) : 0));
            end else begin
                op = i_ops[$urandom_range(6)];
                emit(i_type(op, (op == OP_LUI) ? 0 : $urandom_range(31), $urandom_range(31),
                            16'($urandom)));
            end
        end
        // r28 points at the data area at 80000800
        emit(i_type(OP_LUI, 0, 28, 16'h8000));
        emit(i_type(OP_ORI, 28, 28, 16'h0800));
        for (int n = 0; n < mem_ops; n++) begin
            op = (n < 4 || $urandom_range(1) == 1) ? OP_SW : OP_LW;
            emit(i_type(op, 28, $urandom_range(27), 16'($urandom_range(15) * 4)));
        end
        emit(i_type(OP_ADDIU, 0, 8, 16'd5));
        emit(i_type(OP_ADDIU, 0, 9, 16'd5));
        emit(i_type(OP_BEQ, 8, 9, 16'd1));
        emit(i_type(OP_ADDIU, 0, 10, 16'h0111));
        emit(i_type(OP_BNE, 8, 9, 16'd1));
        emit(i_type(OP_ADDIU, 0, 10, 16'h0222));
        emit(i_type(OP_ADDIU, 0, 9, 16'd7));
        emit(i_type(OP_BNE, 8, 9, 16'd1));
        emit(i_type(OP_ADDIU, 0, 11, 16'h0333));
        emit(i_type(OP_BEQ, 8, 9, 16'd1));
        emit(i_type(OP_ADDIU, 0, 11, 16'h0444));
        p = prog.size();
        emit(j_type(OP_J, p + 2));
        emit(i_type(OP_ADDIU, 0, 12, 16'h0555));
        p = prog.size();
        emit(j_type(OP_JAL, p + 2));
        emit(i_type(OP_ADDIU, 0, 12, 16'h0556));
        // r31 + 16 lands just past the skipped addiu below
        emit(i_type(OP_ADDIU, 31, 13, 16'd16));
        emit(r_type(FN_JR, 13, 0, 0, 0));
        emit(i_type(OP_ADDIU, 0, 14, 16'h0666));
        emit(i_type(OP_ADDIU, 0, 15, 16'd3));
        emit(i_type(OP_ADDIU, 15, 15, 16'hffff));
        emit(i_type(OP_BNE, 15, 0, 16'hfffe));
        emit(i_type(OP_ADDIU, 0, 16, 16'h07ff));
        p = prog.size();
        halt_pc = reset_pc + 32'(p) * 4;
        emit(j_type(OP_J, p));
    endtask

    function automatic void model_step(output logic wrote, output logic [4:0] wnum,
                                       output logic [31:0] wdata, output logic [31:0] ipc);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] ea;
        logic [31:0] npc;
        logic [4:0] sh;
        ins = ref_mem[ref_pc[11:2]];
        a = ref_regs[ins[25:21]];
        b = ref_regs[ins[20:16]];
        simm = {{16{ins[15]}}, ins[15:0]};
        zimm = {16'h0000, ins[15:0]};
        ea = a + simm;
        sh = ins[10:6];
        ipc = ref_pc;
        npc = ref_pc + 32'd4;
        wrote = 1'b1;
        wnum = ins[20:16];
        wdata = 32'h0;
        case (opcode_e'(ins[31:26]))
            OP_SPECIAL: begin
                wnum = ins[15:11];
                case (funct_e'(ins[5:0]))
                    FN_ADDU: wdata = a + b;
                    FN_SUBU: wdata = a - b;
                    FN_AND: wdata = a & b;
                    FN_OR: wdata = a | b;
                    FN_XOR: wdata = a ^ b;
                    FN_NOR: wdata = ~(a | b);
                    FN_SLT: wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: wdata = (a < b) ? 32'd1 : 32'd0;
                    FN_SLL: wdata = b << sh;
                    FN_SRL: wdata = b >> sh;
                    FN_SRA: wdata = $signed(b) >>> sh;
                    FN_JR: begin
                        npc = a;
                        wrote = 1'b0;
                    end
                    default: wrote = 1'b0;
                endcase
            end
            OP_ADDIU: wdata = ea;
            OP_SLTI: wdata = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            OP_SLTIU: wdata = (a < simm) ? 32'd1 : 32'd0;
            OP_ANDI: wdata = a & zimm;
            OP_ORI: wdata = a | zimm;
            OP_XORI: wdata = a ^ zimm;
            OP_LUI: wdata = {ins[15:0], 16'h0000};
            OP_LW: wdata = ref_mem[ea[11:2]];
            OP_SW: begin
                ref_mem[ea[11:2]] = b;
                wrote = 1'b0;
            end
            OP_BEQ: begin
                if (a == b) npc = npc + (simm << 2);
                wrote = 1'b0;
            end
            OP_BNE: begin
                if (a != b) npc = npc + (simm << 2);
                wrote = 1'b0;
            end
            OP_J: begin
                npc = {npc[31:28], ins[25:0], 2'b00};
                wrote = 1'b0;
            end
            OP_JAL: begin
                wdata = npc;
                wnum = link_reg;
                npc = {npc[31:28], ins[25:0], 2'b00};
            end
            default: wrote = 1'b0;
        endcase
        if (wnum == 5'd0) wrote = 1'b0;
        if (wrote) ref_regs[wnum] = wdata;
        ref_pc = npc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_memory();
        for (int i = data_base; i < 1024; i++) begin
            check_value($sformatf("mem[%0d]", i), mem_i.mem[i], ref_mem[i]);
        end
    endtask

    initial begin : first_fetch
        @(posedge arst_n);
        @(negedge clk);
        while (!inst_sram_req) @(negedge clk);
        check_value("inst_sram_addr", inst_sram_addr, 32'h1fc0_0000);
    end

    // request attributes on both ports, all addresses used are kseg0 or kseg1
    initial begin : bus_attributes
        logic is_sw;
        @(posedge arst_n);
        forever begin
            @(negedge clk);
            if (inst_sram_req) begin
                check_value("inst_sram_wr", {31'd0, inst_sram_wr}, 32'd0);
                check_value("inst_sram_size", {30'd0, inst_sram_size}, 32'd2);
                check_value("inst_sram_wstrb", {28'd0, inst_sram_wstrb}, 32'd0);
                check_value("inst_sram_wdata", inst_sram_wdata, 32'd0);
                check_value("inst_sram_addr[31:29]", {29'd0, inst_sram_addr[31:29]}, 32'd0);
            end
            if (data_sram_req) begin
                is_sw = (fetched_inst[31:26] == OP_SW);
                check_value("data_sram_wr", {31'd0, data_sram_wr}, {31'd0, is_sw});
                check_value("data_sram_size", {30'd0, data_sram_size}, 32'd2);
                check_value("data_sram_wstrb", {28'd0, data_sram_wstrb},
                            is_sw ? 32'h0000_000f : 32'h0000_0000);
                check_value("data_sram_addr[31:29]", {29'd0, data_sram_addr[31:29]}, 32'd0);
            end
        end
    end

    // each retired write is matched against the next writing instruction of the model
    initial begin : compare
        logic wrote;
        logic [4:0] wnum;
        logic [31:0] wdata;
        logic [31:0] ipc;
        int steps;
        forever begin
            @(negedge clk);
            if (arst_n && debug_wb_rf_wen != 4'b0000) begin
                check_value("debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'h0000_000f);
                steps = 0;
                wrote = 1'b0;
                while (!wrote && steps < 64) begin
                    model_step(wrote, wnum, wdata, ipc);
                    steps++;
                end
                if (!wrote) begin
                    $display("trace entry at %0t ns has no matching write in the model", $time);
                    other_errors++;
                end else begin
                    check_value("debug_wb_pc", debug_wb_pc, ipc);
                    check_value("debug_wb_rf_wnum", {27'd0, debug_wb_rf_wnum}, {27'd0, wnum});
                    check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, wdata);
                end
            end
        end
    end

    initial begin : main
        int limit;
        logic [31:0] w;
        void'($urandom(seed));
        arst_n = 1'b0;
        build_program();
        for (int i = 0; i < 1024; i++) begin
            w = (32'(i) << 20) ^ (32'(i) * 32'h9e37_79b9);
            if (i < prog.size()) w = prog[i];
            mem_i.mem[i] = w;
            ref_mem[i] = w;
        end
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = 32'h0;
        end
        ref_pc = reset_pc;
        limit = prog.size() * 20 + 200;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        while (ref_pc != halt_pc && cycles < limit) @(posedge clk);
        if (ref_pc != halt_pc) begin
            $display("timeout: core did not reach the final jump within %0d cycles", limit);
            other_errors++;
        end else begin
            repeat (200) @(posedge clk);
            check_memory();
        end
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
                 other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
hdl/mips_isa_pkg.sv
hdl/core_uarch_pkg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/sram_master.sv
hdl/pc_unit.sv
hdl/core_ctrl.sv
hdl/mycpu_top.sv
verification/sram_model.sv
verification/cpu_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary -j 0 -f tb.f --top-module cpu_tb
	./obj_dir/Vcpu_tb | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module cpu_tb

clean:
	rm -rf obj_dir $(LOG)
